// ==== hdl/video_macros.svh ====
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

//////////////////////////////////////////////////
// Common sizes
//////////////////////////////////////////////////
`define VID_CW          11 // Raster counter width
`define AUX_WIN_LEN     32 // Aux data window in clocks
`define DEBOUNCE_CYCLES 16 // Stable time before a switch value is taken

// Switch codes, anything not listed falls back to 720p
`define SW_VGA      4'b0000
`define SW_SVGA     4'b0001
`define SW_XGA      4'b0011
`define SW_HDTV720P 4'b0010
`define SW_SXGA     4'b1000
`define SW_CAMERA   4'b1001

//////////////////////////////////////////////////
// Per-mode raster sizes
//////////////////////////////////////////////////
// 640x480
`define HPIXELS_VGA 11'd640
`define HFNPRCH_VGA 11'd16
`define HSYNCPW_VGA 11'd96
`define HBKPRCH_VGA 11'd48
`define VLINES_VGA  11'd480
`define VFNPRCH_VGA 11'd11
`define VSYNCPW_VGA 11'd2
`define VBKPRCH_VGA 11'd31
// 800x600
`define HPIXELS_SVGA 11'd800
`define HFNPRCH_SVGA 11'd40
`define HSYNCPW_SVGA 11'd128
`define HBKPRCH_SVGA 11'd88
`define VLINES_SVGA  11'd600
`define VFNPRCH_SVGA 11'd1
`define VSYNCPW_SVGA 11'd4
`define VBKPRCH_SVGA 11'd23
// 1024x768
`define HPIXELS_XGA 11'd1024
`define HFNPRCH_XGA 11'd24
`define HSYNCPW_XGA 11'd136
`define HBKPRCH_XGA 11'd160
`define VLINES_XGA  11'd768
`define VFNPRCH_XGA 11'd3
`define VSYNCPW_XGA 11'd6
`define VBKPRCH_XGA 11'd29
// 1280x720
`define HPIXELS_HDTV720P 11'd1280
`define HFNPRCH_HDTV720P 11'd110
`define HSYNCPW_HDTV720P 11'd40
`define HBKPRCH_HDTV720P 11'd220
`define VLINES_HDTV720P  11'd720
`define VFNPRCH_HDTV720P 11'd5
`define VSYNCPW_HDTV720P 11'd5
`define VBKPRCH_HDTV720P 11'd20
// 1280x1024
`define HPIXELS_SXGA 11'd1280
`define HFNPRCH_SXGA 11'd48
`define HSYNCPW_SXGA 11'd112
`define HBKPRCH_SXGA 11'd248
`define VLINES_SXGA  11'd1024
`define VFNPRCH_SXGA 11'd1
`define VSYNCPW_SXGA 11'd3
`define VBKPRCH_SXGA 11'd38
// Camera, 720p with trimmed sync
`define HPIXELS_CAMERA 11'd1280
`define HFNPRCH_CAMERA 11'd110
`define HSYNCPW_CAMERA 11'd39
`define HBKPRCH_CAMERA 11'd220
`define VLINES_CAMERA  11'd720
`define VFNPRCH_CAMERA 11'd4
`define VSYNCPW_CAMERA 11'd4
`define VBKPRCH_CAMERA 11'd22

`endif

// ==== hdl/video_pkg.sv ====
`default_nettype none

`include "video_macros.svh"

package video_pkg;

	// Display modes picked by the switch
	typedef enum logic [2:0] {
		MODE_VGA,
		MODE_SVGA,
		MODE_XGA,
		MODE_HDTV720P,
		MODE_SXGA,
		MODE_CAMERA
	} vmode_e;

	// Terminal counts, all zero based
	typedef struct packed {
		logic [`VID_CW-1:0] tc_hsblnk;  // Last active pixel
		logic [`VID_CW-1:0] tc_hssync;  // Hsync starts after this
		logic [`VID_CW-1:0] tc_hesync;  // Last hsync pixel
		logic [`VID_CW-1:0] tc_heblnk;  // Line total minus one
		logic [`VID_CW-1:0] tc_vsblnk;  // Last active line
		logic [`VID_CW-1:0] tc_vssync;  // Vsync starts after this
		logic [`VID_CW-1:0] tc_vesync;  // Last vsync line
		logic [`VID_CW-1:0] tc_veblnk;  // Frame total minus one
		logic               sync_negative; // 1 = active low syncs
	} mode_timing_t;

endpackage

`default_nettype wire

// ==== hdl/video_timing_if.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "video_macros.svh"

// Raster position and raw flags, all registered
interface video_timing_if;
	logic [`VID_CW-1:0] hcount;
	logic [`VID_CW-1:0] vcount;
	logic               hblnk;     // Past last active pixel
	logic               vblnk;     // Past last active line
	logic               hsync_raw; // Positive sense
	logic               vsync_raw; // Positive sense

	// Counter side
	modport gen (output hcount, vcount, hblnk, vblnk, hsync_raw, vsync_raw);

	// Consumers
	modport sink (input hcount, vcount, hblnk, vblnk, hsync_raw, vsync_raw);
endinterface

`default_nettype wire

// ==== hdl/mode_switch_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "video_macros.svh"

module mode_switch_fsm (
	input  wire                     clk50m_bufg,
	input  wire                     RSTBTN,
	input  wire [3:0]               sw,
	output video_pkg::mode_timing_t mode_timing,
	output logic                    restart
);

	localparam int DB_W = $clog2(`DEBOUNCE_CYCLES);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SETTLE,
		ST_APPLY
	} state_e;

	state_e           state;
	logic [3:0]       sw_meta, sw_sync; // Two-flop synchronizer
	logic [3:0]       sw_cand;          // Value being timed
	logic [3:0]       sw_cur;           // Last accepted value
	logic [DB_W-1:0]  db_cnt;

	// Switch code to mode
	function automatic video_pkg::vmode_e sw_to_mode(input logic [3:0] code);
		case (code)
			`SW_VGA:    sw_to_mode = video_pkg::MODE_VGA;
			`SW_SVGA:   sw_to_mode = video_pkg::MODE_SVGA;
			`SW_XGA:    sw_to_mode = video_pkg::MODE_XGA;
			`SW_SXGA:   sw_to_mode = video_pkg::MODE_SXGA;
			`SW_CAMERA: sw_to_mode = video_pkg::MODE_CAMERA;
			default:    sw_to_mode = video_pkg::MODE_HDTV720P;
		endcase
	endfunction

	// Sizes to terminal counts
	function automatic video_pkg::mode_timing_t build_tc(
		input logic [`VID_CW-1:0] hp, hf, hs, hb,
		input logic [`VID_CW-1:0] vl, vf, vs, vb,
		input logic               neg
	);
		video_pkg::mode_timing_t t;
		t.tc_hsblnk     = hp - 11'd1;
		t.tc_hssync     = hp - 11'd1 + hf;
		t.tc_hesync     = hp - 11'd1 + hf + hs;
		t.tc_heblnk     = hp - 11'd1 + hf + hs + hb;
		t.tc_vsblnk     = vl - 11'd1;
		t.tc_vssync     = vl - 11'd1 + vf;
		t.tc_vesync     = vl - 11'd1 + vf + vs;
		t.tc_veblnk     = vl - 11'd1 + vf + vs + vb;
		t.sync_negative = neg;
		return t;
	endfunction

	//////////////////////////////////////////////////
	// Mode table
	//////////////////////////////////////////////////
	function automatic video_pkg::mode_timing_t mode_lookup(input video_pkg::vmode_e m);
		case (m)
			video_pkg::MODE_VGA: mode_lookup = build_tc( // Negative syncs
				`HPIXELS_VGA, `HFNPRCH_VGA, `HSYNCPW_VGA, `HBKPRCH_VGA,
				`VLINES_VGA, `VFNPRCH_VGA, `VSYNCPW_VGA, `VBKPRCH_VGA, 1'b1);
			video_pkg::MODE_SVGA: mode_lookup = build_tc(
				`HPIXELS_SVGA, `HFNPRCH_SVGA, `HSYNCPW_SVGA, `HBKPRCH_SVGA,
				`VLINES_SVGA, `VFNPRCH_SVGA, `VSYNCPW_SVGA, `VBKPRCH_SVGA, 1'b0);
			video_pkg::MODE_XGA: mode_lookup = build_tc( // Negative syncs
				`HPIXELS_XGA, `HFNPRCH_XGA, `HSYNCPW_XGA, `HBKPRCH_XGA,
				`VLINES_XGA, `VFNPRCH_XGA, `VSYNCPW_XGA, `VBKPRCH_XGA, 1'b1);
			video_pkg::MODE_SXGA: mode_lookup = build_tc(
				`HPIXELS_SXGA, `HFNPRCH_SXGA, `HSYNCPW_SXGA, `HBKPRCH_SXGA,
				`VLINES_SXGA, `VFNPRCH_SXGA, `VSYNCPW_SXGA, `VBKPRCH_SXGA, 1'b0);
			video_pkg::MODE_CAMERA: mode_lookup = build_tc(
				`HPIXELS_CAMERA, `HFNPRCH_CAMERA, `HSYNCPW_CAMERA, `HBKPRCH_CAMERA,
				`VLINES_CAMERA, `VFNPRCH_CAMERA, `VSYNCPW_CAMERA, `VBKPRCH_CAMERA, 1'b0);
			default: mode_lookup = build_tc(
				`HPIXELS_HDTV720P, `HFNPRCH_HDTV720P, `HSYNCPW_HDTV720P, `HBKPRCH_HDTV720P,
				`VLINES_HDTV720P, `VFNPRCH_HDTV720P, `VSYNCPW_HDTV720P, `VBKPRCH_HDTV720P,
				1'b0);
		endcase
	endfunction

	always_ff @(posedge clk50m_bufg) begin
		sw_meta <= sw;
		sw_sync <= sw_meta;
	end

	//////////////////////////////////////////////////
	// Debounce and apply
	//////////////////////////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			state       <= ST_APPLY; // Forces one restart out of reset
			sw_cand     <= `SW_HDTV720P;
			sw_cur      <= `SW_HDTV720P;
			db_cnt      <= '0;
			restart     <= 1'b0;
			mode_timing <= mode_lookup(video_pkg::MODE_HDTV720P);
		end else begin
			restart <= 1'b0; // Single cycle pulse
			case (state)
				ST_IDLE: begin
					if (sw_sync != sw_cur) begin
						sw_cand <= sw_sync;
						db_cnt  <= '0;
						state   <= ST_SETTLE;
					end
				end
				ST_SETTLE: begin
					if (sw_sync != sw_cand)
						state <= ST_IDLE; // Glitch, start over
					else if (db_cnt == DB_W'(`DEBOUNCE_CYCLES - 1))
						state <= ST_APPLY;
					else
						db_cnt <= db_cnt + 1'b1;
				end
				ST_APPLY: begin
					mode_timing <= mode_lookup(sw_to_mode(sw_cand));
					sw_cur      <= sw_cand;
					restart     <= 1'b1; // Same edge as new timing
					state       <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/video_timing_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "video_macros.svh"

module video_timing_gen (
	input  wire                     clk50m_bufg,
	input  wire                     RSTBTN,
	input  wire                     restart,
	input  wire video_pkg::mode_timing_t mode_timing,
	video_timing_if.gen             vt
);

	logic [`VID_CW-1:0] hcount_nxt;
	logic [`VID_CW-1:0] vcount_nxt;
	logic               h_wrap; // Last pixel of the line
	logic               v_wrap; // Last line of the frame

	//////////////////////////////////////////////////
	// Next counter values
	//////////////////////////////////////////////////
	always_comb begin
		h_wrap = (vt.hcount >= mode_timing.tc_heblnk); // >= covers a shrinking mode
		v_wrap = (vt.vcount >= mode_timing.tc_veblnk);

		if (restart || h_wrap)
			hcount_nxt = '0;
		else
			hcount_nxt = vt.hcount + 1'b1;

		// Vertical only moves at the end of a line
		if (restart)
			vcount_nxt = '0;
		else if (h_wrap)
			vcount_nxt = v_wrap ? '0 : vt.vcount + 1'b1;
		else
			vcount_nxt = vt.vcount;
	end

	//////////////////////////////////////////////////
	// Counters and flags
	//////////////////////////////////////////////////
	// Flags decode the next count so they line up with it
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			vt.hcount    <= '0;
			vt.vcount    <= '0;
			vt.hblnk     <= 1'b0;
			vt.vblnk     <= 1'b0;
			vt.hsync_raw <= 1'b0;
			vt.vsync_raw <= 1'b0;
		end else begin
			vt.hcount <= hcount_nxt;
			vt.vcount <= vcount_nxt;

			vt.hblnk     <= (hcount_nxt > mode_timing.tc_hsblnk); // Front porch onward
			vt.hsync_raw <= (hcount_nxt > mode_timing.tc_hssync) &&
			                (hcount_nxt <= mode_timing.tc_hesync);

			// Same decode in lines
			vt.vblnk     <= (vcount_nxt > mode_timing.tc_vsblnk);
			vt.vsync_raw <= (vcount_nxt > mode_timing.tc_vssync) &&
			                (vcount_nxt <= mode_timing.tc_vesync);
		end
	end

endmodule

`default_nettype wire

// ==== hdl/sync_de_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module sync_de_stage (
	input  wire          clk50m_bufg,
	input  wire          RSTBTN,
	video_timing_if.sink vt,
	input  wire          sync_negative, // 1 = active low
	output logic         hsync,
	output logic         vsync,
	output logic         de
);

	logic hsync_q;
	logic vsync_q;
	logic active_q;
	logic active;

	// Visible area
	assign active = !vt.hblnk && !vt.vblnk;

	//////////////////////////////////////////////////
	// Two register stages
	//////////////////////////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			hsync_q  <= 1'b0; // Idle level of positive sync
			vsync_q  <= 1'b0;
			active_q <= 1'b0;
			hsync    <= 1'b0;
			vsync    <= 1'b0;
			de       <= 1'b0;
		end else begin
			// Stage 1 with polarity
			hsync_q  <= vt.hsync_raw ^ sync_negative;
			vsync_q  <= vt.vsync_raw ^ sync_negative;
			active_q <= active;

			hsync <= hsync_q; // Stage 2
			vsync <= vsync_q;
			de    <= active_q;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/aux_window_sched.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "video_macros.svh"

module aux_window_sched (
	input  wire               clk50m_bufg,
	input  wire               RSTBTN,
	video_timing_if.sink      vt,
	input  wire [`VID_CW-1:0] aux_start,
	output logic              ade
);

	localparam int AW = $clog2(`AUX_WIN_LEN);

	logic [`VID_CW-1:0] aux_col;  // Column for this line
	logic [AW-1:0]      win_cnt;  // Cycles already in window
	logic               win_q;    // Window, one stage behind vt
	logic               open;
	logic               line_start;

	assign line_start = (vt.hcount == '0);

	// Start point only in horizontal blanking of an active line
	assign open = !win_q && vt.hblnk && !vt.vblnk && (vt.hcount == aux_col);

	// Column taken once per line
	always_ff @(posedge clk50m_bufg) begin
		if (line_start)
			aux_col <= aux_start;
	end

	//////////////////////////////////////////////////
	// Window counter
	//////////////////////////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			win_q   <= 1'b0;
			win_cnt <= '0;
			ade     <= 1'b0;
		end else begin
			if (open) begin
				win_q   <= 1'b1;
				win_cnt <= '0;
			end else if (win_q) begin
				// Full length reached or new line began
				if (win_cnt == AW'(`AUX_WIN_LEN - 1) || line_start)
					win_q <= 1'b0;
				else
					win_cnt <= win_cnt + 1'b1;
			end

			ade <= win_q; // Second stage, lines up with de
		end
	end

endmodule

`default_nettype wire

// ==== hdl/video_tx_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "video_macros.svh"

module video_tx_top (
	input  wire               clk50m_bufg,
	input  wire               RSTBTN,
	input  wire [3:0]         sw,        // Mode select
	input  wire [`VID_CW-1:0] aux_start, // Aux column in blanking
	output logic              hsync,
	output logic              vsync,
	output logic              de,
	output logic              ade
);

	video_pkg::mode_timing_t mode_timing;
	logic                    restart;

	video_timing_if vt_if ();

	//////////////////////////////////////////////////
	// Mode select
	//////////////////////////////////////////////////
	mode_switch_fsm mode_switch_fsm_inst (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.sw          (sw),
		.mode_timing (mode_timing),
		.restart     (restart)
	);

	// Raster counters
	video_timing_gen video_timing_gen_inst (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.restart     (restart),
		.mode_timing (mode_timing),
		.vt          (vt_if.gen)
	);

	//////////////////////////////////////////////////
	// Output stages, both two clocks behind vt
	//////////////////////////////////////////////////
	sync_de_stage sync_de_stage_inst (
		.clk50m_bufg   (clk50m_bufg),
		.RSTBTN        (RSTBTN),
		.vt            (vt_if.sink),
		.sync_negative (mode_timing.sync_negative),
		.hsync         (hsync),
		.vsync         (vsync),
		.de            (de)
	);

	aux_window_sched aux_window_sched_inst (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.vt          (vt_if.sink),
		.aux_start   (aux_start),
		.ade         (ade)
	);

endmodule

`default_nettype wire

// ==== tests/video_tx_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "video_macros.svh"

module video_tx_tb;

	localparam int N_ROWS           = 7;
	localparam int N_COLS           = 9;         // Words per stimulus row
	localparam int VGA_FRAME_CYCLES = 800 * 525; // Upper bound of one VGA frame

	logic               clk50m_bufg = 1'b0;
	logic               RSTBTN      = 1'b1;
	logic [3:0]         sw          = `SW_HDTV720P; // Same as reset mode
	logic [`VID_CW-1:0] aux_start   = '0;
	wire                hsync;
	wire                vsync;
	wire                de;
	wire                ade;

	logic [31:0] stim [0:N_ROWS*N_COLS-1];
	int          seed        = 32'h4d50;
	int unsigned run_cycles  = 0;
	int unsigned cycle_limit = 0;

	// Current row
	int   r_sw, r_aux, r_lines, r_htot, r_hsw, r_hpix, r_vlines, r_vsw;
	logic pol_neg; // 1 = active low syncs
	logic exp_win; // Column lies in blanking
	int   exp_len; // Expected ade cycles per line

	// Samples with syncs folded to active high
	logic hs_a, hs_q, vs_a, vs_q, de_s, de_q, ade_s, ade_q;
	int   cyc;
	int   de_fall_cyc;

	always #10 clk50m_bufg = ~clk50m_bufg; // 50 MHz

	video_tx_top video_tx_top_inst (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.sw          (sw),
		.aux_start   (aux_start),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de),
		.ade         (ade)
	);

	// Run length guard
	always @(posedge clk50m_bufg) begin
		run_cycles <= run_cycles + 1;
		if (cycle_limit != 0 && run_cycles >= cycle_limit) begin
			$display("Timeout, the run did not finish within %0d cycles", cycle_limit);
			$display("Some tests failed");
			$fatal(1, "timeout");
		end
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////
	task automatic check_eq(input int actual, input int expected, input string what);
		if (actual != expected) begin
			$display("FAIL %0t ns: %s, got %0d, expected %0d", $time, what, actual, expected);
			$display("Some tests failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// One sample per clock at the falling edge
	task automatic sample_cycle();
		@(negedge clk50m_bufg);
		hs_q  = hs_a;
		vs_q  = vs_a;
		de_q  = de_s;
		ade_q = ade_s;
		hs_a  = hsync ^ pol_neg;
		vs_a  = vsync ^ pol_neg;
		de_s  = de;
		ade_s = ade;
		cyc++;
		if (de_q && !de_s)
			de_fall_cyc = cyc; // First blank pixel
	endtask

	// From one hsync leading edge to the next
	task automatic measure_line(input int r, input int l);
		int period;
		int hs_cnt;
		int de_cnt;
		int ade_cnt;
		int ade_rise;
		bit done;
		period   = 0;
		hs_cnt   = 0;
		de_cnt   = 0;
		ade_cnt  = 0;
		ade_rise = 0;
		done     = 1'b0;
		while (!done) begin
			sample_cycle();
			period++;
			if (hs_a) hs_cnt++;
			if (de_s) de_cnt++;
			if (ade_s) ade_cnt++;
			if (ade_s && de_s)
				check_eq(1, 0, $sformatf("row %0d line %0d ade overlaps de", r, l));
			if (ade_s && !ade_q) begin
				ade_rise++;
				check_eq(cyc - de_fall_cyc, r_aux - r_hpix,
					$sformatf("row %0d line %0d gap de to ade", r, l));
			end
			done = hs_a && !hs_q;
		end
		check_eq(period, r_htot, $sformatf("row %0d line %0d line period", r, l));
		check_eq(hs_cnt, r_hsw, $sformatf("row %0d line %0d hsync width", r, l));
		check_eq(de_cnt, r_hpix, $sformatf("row %0d line %0d de length", r, l));
		check_eq(ade_cnt, exp_len,
			$sformatf("row %0d line %0d ade length", r, l));
		check_eq(ade_rise, exp_win ? 1 : 0,
			$sformatf("row %0d line %0d ade windows", r, l));
	endtask

	task automatic drive_glitch(input logic [3:0] code, input logic [3:0] home, input int len);
		@(posedge clk50m_bufg);
		sw <= code;
		repeat (len) @(posedge clk50m_bufg);
		sw <= home; // Back before debounce ends
	endtask

	// Vsync edge to vsync edge
	task automatic check_frame(input int r);
		int vs_cnt;
		int de_rises;
		vs_cnt   = 0;
		de_rises = 0;
		do begin
			sample_cycle();
		end while (!(vs_a && !vs_q));
		do begin
			sample_cycle();
			if (vs_a) vs_cnt++;
			if (de_s && !de_q) de_rises++; // One per active line
		end while (!(vs_a && !vs_q));
		check_eq(de_rises, r_vlines, $sformatf("row %0d active lines per frame", r));
		check_eq(vs_cnt, r_vsw * r_htot, $sformatf("row %0d vsync width", r));
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////
	initial begin
		int          i;
		int          r;
		int          l;
		int          glen;
		int unsigned budget;
		for (i = 0; i < N_ROWS * N_COLS; i++)
			stim[i] = 32'hFFFF_FFFF; // Marks words the file did not fill
		$readmemh("tests/video_tx_stimulus.txt", stim);
		if (stim[N_ROWS*N_COLS-1] == 32'hFFFF_FFFF) begin
			$display("The stimulus file is missing or has too few rows");
			$display("Some tests failed");
			$fatal(1, "no stimulus");
		end
		budget = VGA_FRAME_CYCLES + `DEBOUNCE_CYCLES;
		for (r = 0; r < N_ROWS; r++)
			budget = budget + (stim[r*N_COLS+2] + 2) * stim[r*N_COLS+3];
		cycle_limit = 2 * budget;

		hs_a        = 1'b0;
		vs_a        = 1'b0;
		de_s        = 1'b0;
		ade_s       = 1'b0;
		pol_neg     = 1'b0; // 720p after reset
		cyc         = 0;
		de_fall_cyc = 0;

		repeat (5) @(posedge clk50m_bufg);
		RSTBTN <= 1'b0;
		sample_cycle(); // Still reset values here
		check_eq(hsync ? 1 : 0, 0, "hsync after reset");
		check_eq(vsync ? 1 : 0, 0, "vsync after reset");
		check_eq(de ? 1 : 0, 0, "de after reset");
		check_eq(ade ? 1 : 0, 0, "ade after reset");

		for (r = 0; r < N_ROWS; r++) begin
			r_sw     = int'(stim[r*N_COLS+0]);
			r_aux    = int'(stim[r*N_COLS+1]);
			r_lines  = int'(stim[r*N_COLS+2]);
			r_htot   = int'(stim[r*N_COLS+3]);
			r_hsw    = int'(stim[r*N_COLS+4]);
			r_hpix   = int'(stim[r*N_COLS+5]);
			pol_neg  = stim[r*N_COLS+6][0];
			r_vlines = int'(stim[r*N_COLS+7]);
			r_vsw    = int'(stim[r*N_COLS+8]);
			exp_win  = (r_aux >= r_hpix) && (r_aux < r_htot);
			// Window ends early at the line end
			if (!exp_win)
				exp_len = 0;
			else if (r_htot - r_aux < `AUX_WIN_LEN)
				exp_len = r_htot - r_aux;
			else
				exp_len = `AUX_WIN_LEN;

			@(posedge clk50m_bufg);
			sw        <= 4'(r_sw);
			aux_start <= `VID_CW'(r_aux);
			repeat (`DEBOUNCE_CYCLES + 16) sample_cycle(); // Debounce plus restart
			// Line 0 may still hold the old column
			repeat (2) begin
				do begin
					sample_cycle();
				end while (!(hs_a && !hs_q));
			end
			for (l = 0; l < r_lines; l++)
				measure_line(r, l);

			// Short switch change must leave the period
			glen = 1 + int'($unsigned($random(seed)) % (`DEBOUNCE_CYCLES - 1));
			fork
				drive_glitch(4'(r_sw) ^ 4'b0100, 4'(r_sw), glen);
				measure_line(r, r_lines);
			join

			if (r_vlines != 0)
				check_frame(r);
		end

		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/video_tx_stimulus.txt ====
// Hex words per row: sw aux_col lines htotal hsync_w hpixels polarity vlines vsync_w
// Polarity 1 is negative sync and vlines 0 skips the frame check
2 5DC 3 672 28 500 0 000 0 // 720p, column in back porch
0 2BC 3 320 60 280 1 1E0 2 // VGA with full frame check
1 384 3 420 80 320 0 000 0 // SVGA, window inside hsync
3 064 3 540 88 400 1 000 0 // XGA, column in active area
8 578 3 698 70 500 0 000 0 // SXGA
9 640 3 671 27 500 0 000 0 // Camera, window ends near line end
7 7D0 3 672 28 500 0 000 0 // Unlisted code, column past line total

// ==== src.f ====
+incdir+hdl
hdl/video_pkg.sv
hdl/video_timing_if.sv
hdl/mode_switch_fsm.sv
hdl/video_timing_gen.sv
hdl/sync_de_stage.sv
hdl/aux_window_sched.sv
hdl/video_tx_top.sv
tests/video_tx_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the video timing testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --timescale 1ns/1ns -f src.f --top-module video_tx_tb -o video_tx_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/video_tx_sim > "$log" 2>&1
sim_status=$?
cat "$log"

if grep -q "Some tests failed" "$log"; then
	echo "Simulation reported failure"
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "Simulator exited with status $sim_status"
	exit 1
fi
echo "Simulation finished without failures"
